// ==== bench/vid_properties.sv ====
`timescale 1ns/1ps

module vid_properties
    import vid_pkg::*;
(
    input logic      clk32,
    input logic      porb,
    input beam_t     beam_i,
    input fetch_t    fetch_i,
    input beam_pos_t pos_i
);

    // Display enable only inside the unblanked area
    assert property (@(posedge clk32) disable iff (!porb) beam_i.de |-> beam_i.blank_n)
        else $error("de high while blanked");

    assert property (@(posedge clk32) disable iff (!porb) fetch_i.valid |-> beam_i.de)
        else $error("fetch outside display enable");

    assert property (@(posedge clk32) disable iff (!porb) !beam_i.hsync_n |-> !beam_i.de)
        else $error("de high during hsync");

    // Beam moves only on the edge after a word period
    assert property (@(posedge clk32) disable iff (!porb)
                     $changed(beam_i) |-> $past(pos_i.word_en))
        else $error("beam changed outside a word edge");

endmodule

bind vid_top vid_properties u_props (
    .clk32   (clk32),
    .porb    (porb),
    .beam_i  (beam_o),
    .fetch_i (fetch_o),
    .pos_i   (pos)
);

// ==== bench/vid_tb.sv ====
`timescale 1ns/1ps
`include "vid_macros.svh"

module vid_tb
    import vid_pkg::*;
();

    localparam int TIMEOUT_CYC = 6_000_000;     // Six frames, longest PAL, plus margin

    logic        clk32 = 1'b0;
    logic        porb;
    regbus_t     bus_i;
    logic [7:0]  rdata_o;
    beam_t       beam_o;
    fetch_t      fetch_o;

    logic [31:0] rng;
    int          ncyc;
    int          total_cyc;
    // Register shadows and per-frame model state
    vid_cfg_t    sh_cfg;
    vid_addr_t   sh_base;
    logic [7:0]  sh_hoff;
    vid_addr_t   m_fbase;
    bit          started;
    int          m_h, m_v, frames, de_words;
    int          m_l, m_f, m_hsw, m_hs, m_he, m_vs, m_ve, m_vbs, m_vbe;
    bit          m_mono;
    logic [7:0]  offs [13] = '{8'h01, 8'h03, 8'h05, 8'h07, 8'h09, 8'h0A, 8'h0D,
                               8'h0F, 8'h60, 8'h00, 8'h0B, 8'h61, 8'hFF};

    vid_top u_dut (
        .clk32   (clk32),
        .porb    (porb),
        .bus_i   (bus_i),
        .rdata_o (rdata_o),
        .beam_o  (beam_o),
        .fetch_o (fetch_o)
    );

    always #5 clk32 = ~clk32;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            fail_stop($sformatf("FAILED at %0t: read %s got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_beam(input beam_t got, input beam_t exp);
        if (got !== exp)
            fail_stop($sformatf("FAILED at %0t: beam got %b expected %b (h %0d v %0d)",
                                $time, got, exp, m_h, m_v));
    endtask

    task automatic check_fetch(input fetch_t got, input fetch_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.addr !== exp.addr))
            fail_stop($sformatf("FAILED at %0t: fetch got %b/%h expected %b/%h",
                                $time, got.valid, got.addr, exp.valid, exp.addr));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            fail_stop($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    // Expected readback from the register rules
    function automatic logic [7:0] expected_read(input logic [7:0] a);
        case (a)
            `VID_RA_BASE_HI:  return {2'b00, sh_base[20:15]};
            `VID_RA_BASE_MID: return sh_base[14:7];
            `VID_RA_BASE_LO:  return {sh_base[6:0], 1'b0};
            `VID_RA_CNT_HI:   return {2'b00, m_fbase[20:15]};
            `VID_RA_CNT_MID:  return m_fbase[14:7];
            `VID_RA_CNT_LO:   return {m_fbase[6:0], 1'b0};
            `VID_RA_SYNC:     return {6'h3F, sh_cfg.pal, 1'b1};
            `VID_RA_MODE:     return {6'h00, sh_cfg.shift};
            `VID_RA_HOFF:     return sh_hoff;
            default:          return 8'hFF;
        endcase
    endfunction

    task automatic reg_write(input logic [7:0] a, input logic [7:0] d);
        @(negedge clk32);
        bus_i = '{sel: 1'b1, wr: 1'b1, addr: a, wdata: d};
        case (a)
            `VID_RA_BASE_HI:  sh_base[20:15] = d[5:0];
            `VID_RA_BASE_MID: sh_base[14:7] = d;
            `VID_RA_BASE_LO:  sh_base[6:0] = d[7:1];
            `VID_RA_SYNC:     sh_cfg.pal = d[1];
            `VID_RA_MODE:     sh_cfg.shift = shift_mode_e'(d[1:0]);
            `VID_RA_HOFF:     sh_hoff = d;
            default: ;
        endcase
        @(negedge clk32);
        bus_i = '0;
    endtask

    task automatic reg_read_check(input logic [7:0] a);
        @(negedge clk32);
        bus_i = '{sel: 1'b1, wr: 1'b0, addr: a, wdata: 8'h00};
        #2;
        check_rdata(rdata_o, expected_read(a), $sformatf("offset %h", a));
        @(negedge clk32);
        bus_i = '0;
    endtask

    task automatic load_geometry(input vid_cfg_t c);
        m_mono = c.shift[1];
        m_vbs  = c.pal ? `VID_VBL_START_PAL : `VID_VBL_START_NTSC;
        m_vbe  = c.pal ? `VID_VBL_END_PAL : `VID_VBL_END_NTSC;
        if (m_mono) begin
            m_l   = `VID_LINE_MONO;
            m_f   = `VID_FRAME_MONO;
            m_hsw = `VID_HSYNC_W_MONO;
            m_hs  = `VID_HDE_START_MONO;
            m_he  = `VID_HDE_END_MONO;
            m_vs  = `VID_VDE_START_MONO;
            m_ve  = `VID_VDE_END_MONO;
        end else if (c.pal) begin
            m_l   = `VID_LINE_PAL;
            m_f   = `VID_FRAME_PAL;
            m_hsw = `VID_HSYNC_W;
            m_hs  = `VID_HDE_START_PAL;
            m_he  = `VID_HDE_END_PAL;
            m_vs  = `VID_VDE_START_PAL;
            m_ve  = `VID_VDE_END_PAL;
        end else begin
            m_l   = `VID_LINE_NTSC;
            m_f   = `VID_FRAME_NTSC;
            m_hsw = `VID_HSYNC_W;
            m_hs  = `VID_HDE_START_NTSC;
            m_he  = `VID_HDE_END_NTSC;
            m_vs  = `VID_VDE_START_NTSC;
            m_ve  = `VID_VDE_END_NTSC;
        end
    endtask

    // ==================================================================
    // Reference model, one step per word period
    // ==================================================================
    task automatic word_step();
        beam_t  eb;
        fetch_t ef;
        int     lin;
        if (!started) begin
            started = 1'b1;
            m_h = 0;
            m_v = 0;
        end else begin
            m_h++;
            if (m_h == m_l) begin
                m_h = 0;
                m_v = (m_v + 1 == m_f) ? 0 : m_v + 1;
            end
        end
        if (m_h == 0 && m_v == 0) begin
            if (frames > 0)
                check_count(de_words, (m_he - m_hs) * (m_ve - m_vs), "DE words per frame");
            load_geometry(sh_cfg);       // Geometry fixed for the whole frame
            m_fbase  = sh_base;
            de_words = 0;
            frames++;
        end
        eb.hsync_n = (m_h < m_l - m_hsw);
        eb.vsync_n = (m_v < m_f - `VID_VSYNC_LINES);
        eb.de      = (m_h >= m_hs && m_h < m_he && m_v >= m_vs && m_v < m_ve);
        eb.blank_n = m_mono || (m_h >= `VID_HBL_START && m_h < `VID_HBL_END &&
                                m_v >= m_vbs && m_v < m_vbe);
        check_beam(beam_o, eb);
        // Offset is taken live at each DE fall
        lin      = (m_v - m_vs) * (m_he - m_hs + int'(sh_hoff)) + (m_h - m_hs);
        ef.valid = eb.de;
        ef.addr  = m_fbase + vid_addr_t'(lin);
        check_fetch(fetch_o, ef);
        if (beam_o.de) de_words++;
    endtask

    always @(posedge clk32 or negedge porb) begin
        if (!porb) ncyc <= 0;
        else ncyc <= ncyc + 1;
    end

    always @(posedge clk32) begin
        total_cyc++;
        if (total_cyc >= TIMEOUT_CYC)
            fail_stop("Timeout: the run did not reach its last frame within the cycle limit");
    end

    always @(negedge clk32) begin
        if (!porb || ncyc < 17)
            check_beam(beam_o, '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0, blank_n: 1'b0});
        if (porb && ncyc >= 17 && ((ncyc - 17) % 16) == 0)
            word_step();
        else
            check_fetch(fetch_o, '0);
    end

    initial begin
        logic [7:0] a;
        bus_i     = '0;
        porb      = 1'b0;
        rng       = 32'h48abcf7c;
        total_cyc = 0;
        sh_cfg    = '0;
        sh_base   = '0;
        sh_hoff   = '0;
        m_fbase   = '0;
        started   = 1'b0;
        frames    = 0;
        de_words  = 0;
        load_geometry('0);
        repeat (10) @(negedge clk32);
        porb = 1'b1;
        repeat (100) @(negedge clk32);

        // Random register traffic near the top of the first frame
        for (int i = 0; i < 40; i++) begin
            a = offs[xorshift() % 13];
            reg_write(a, 8'(xorshift()));
            reg_read_check(a);
        end

        reg_write(`VID_RA_SYNC, 8'h02);
        reg_write(`VID_RA_MODE, 8'h00);
        reg_write(`VID_RA_BASE_HI, 8'(xorshift()));
        reg_write(`VID_RA_BASE_MID, 8'(xorshift()));
        reg_write(`VID_RA_BASE_LO, 8'(xorshift()));
        reg_write(`VID_RA_HOFF, 8'(xorshift()));

        // Mono selected mid-frame in the second PAL frame
        while (!(frames == 3 && m_v >= 150)) @(negedge clk32);
        reg_write(`VID_RA_MODE, 8'h02);
        reg_read_check(`VID_RA_MODE);

        // New base and offset below the mono active area
        while (!(frames == 5 && m_v >= 470)) @(negedge clk32);
        reg_write(`VID_RA_BASE_HI, 8'(xorshift()));
        reg_write(`VID_RA_BASE_MID, 8'(xorshift()));
        reg_write(`VID_RA_BASE_LO, 8'(xorshift()));
        reg_write(`VID_RA_HOFF, 8'(xorshift()));

        while (frames < 7) @(negedge clk32);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/vid_pkg.sv
logic/cpu_reg.sv
logic/vid_regs.sv
logic/beam_timer.sv
logic/display_window_fsm.sv
logic/vid_addr_cnt.sv
logic/vid_top.sv
bench/vid_properties.sv
bench/vid_tb.sv

// ==== logic/beam_timer.sv ====
`timescale 1ns/1ps
`include "vid_macros.svh"

module beam_timer
    import vid_pkg::*;
(
    input  logic      clk32,
    input  logic      porb,
    input  vid_cfg_t  cfg_i,
    output beam_pos_t pos_o,
    output logic      hsync_n_o,
    output logic      vsync_n_o
);

    localparam int DIV_W = $clog2(`VID_WORD_DIV);

    logic [DIV_W-1:0] div_q;
    logic             wrap;
    vid_cfg_t         geo_q;             // Geometry of the running frame
    logic [6:0]       line_last;
    logic [6:0]       hsync_first;
    logic [8:0]       frame_last;
    logic [8:0]       vsync_first;
    logic [6:0]       hpos_nx;
    logic [8:0]       vpos_nx;
    beam_pos_t        pos_q;
    logic             hsync_n_q;
    logic             vsync_n_q;

    assign wrap = (div_q == DIV_W'(`VID_WORD_DIV - 1));

    // Line and frame limits of the latched geometry
    always_comb begin
        if (geo_q.shift[1]) begin
            line_last   = 7'(`VID_LINE_MONO - 1);
            hsync_first = 7'(`VID_LINE_MONO - `VID_HSYNC_W_MONO);
            frame_last  = 9'(`VID_FRAME_MONO - 1);
        end else if (geo_q.pal) begin
            line_last   = 7'(`VID_LINE_PAL - 1);
            hsync_first = 7'(`VID_LINE_PAL - `VID_HSYNC_W);
            frame_last  = 9'(`VID_FRAME_PAL - 1);
        end else begin
            line_last   = 7'(`VID_LINE_NTSC - 1);
            hsync_first = 7'(`VID_LINE_NTSC - `VID_HSYNC_W);
            frame_last  = 9'(`VID_FRAME_NTSC - 1);
        end
        vsync_first = frame_last - 9'(`VID_VSYNC_LINES - 1);
    end

    // Out of range positions after reset wrap straight to 0,0
    always_comb begin
        hpos_nx = pos_q.hpos + 7'd1;
        vpos_nx = pos_q.vpos;
        if (pos_q.hpos >= line_last) begin
            hpos_nx = '0;
            vpos_nx = (pos_q.vpos >= frame_last) ? '0 : pos_q.vpos + 9'd1;
        end
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            div_q             <= '0;
            pos_q.hpos        <= '1;
            pos_q.vpos        <= '1;
            pos_q.word_en     <= 1'b0;
            pos_q.frame_start <= 1'b0;
            hsync_n_q         <= 1'b1;
            vsync_n_q         <= 1'b1;
            geo_q             <= '0;
        end else begin
            div_q             <= wrap ? '0 : div_q + DIV_W'(1);
            pos_q.word_en     <= wrap;
            pos_q.frame_start <= wrap && hpos_nx == '0 && vpos_nx == '0;
            if (wrap) begin
                pos_q.hpos <= hpos_nx;
                pos_q.vpos <= vpos_nx;
                hsync_n_q  <= (hpos_nx < hsync_first);   // Last words of the line
                vsync_n_q  <= (vpos_nx < vsync_first);   // Last lines of the frame
            end
            // Same edge as the window FSM takes its copy
            if (pos_q.word_en && pos_q.frame_start) begin
                geo_q <= cfg_i;
            end
        end
    end

    assign pos_o     = pos_q;
    assign hsync_n_o = hsync_n_q;
    assign vsync_n_o = vsync_n_q;

endmodule

// ==== logic/cpu_reg.sv ====
`timescale 1ns/1ps

module cpu_reg
    import vid_pkg::*;
#(
    parameter type      payload_t = vid_addr_t,
    parameter payload_t RST_VAL   = '0
) (
    input  logic     clk32,
    input  logic     porb,
    input  logic     load_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            q <= RST_VAL;
        end else if (load_i) begin
            q <= d_i;                // Write lands on the strobe edge
        end
    end

    assign q_o = q;

endmodule

// ==== logic/display_window_fsm.sv ====
`timescale 1ns/1ps
`include "vid_macros.svh"

module display_window_fsm
    import vid_pkg::*;
(
    input  logic      clk32,
    input  logic      porb,
    input  beam_pos_t pos_i,
    input  logic      hsync_n_i,
    input  logic      vsync_n_i,
    input  vid_cfg_t  cfg_i,
    output beam_t     beam_o,
    output logic      de_o
);

    typedef enum logic [2:0] {
        V_TOP_BLANK,
        V_BORDER_TOP,
        V_ACTIVE,
        V_BORDER_BOT,
        V_BOT_BLANK
    } vstate_e;

    vstate_e    state_q;
    vstate_e    state_nx;
    vid_cfg_t   geo_q;
    vid_cfg_t   geo;
    logic       new_frame;
    logic       line_start;
    logic       mono;
    logic [6:0] hde_start;
    logic [6:0] hde_end;
    logic [8:0] vde_start;
    logic [8:0] vde_end;
    logic [8:0] vbl_start;
    logic [8:0] vbl_end;
    logic       hde_q;
    logic       hde_nx;
    logic       hbl_q;
    logic       hbl_nx;
    logic       de_nx;
    logic       vvis;
    beam_t      beam_q;

    assign new_frame  = pos_i.word_en & pos_i.frame_start;
    assign line_start = pos_i.word_en & (pos_i.hpos == 7'd0);
    assign geo        = new_frame ? cfg_i : geo_q;  // New geometry from word 0
    assign mono       = geo.shift[1];

    // ==================================================================
    // Window positions per geometry
    // ==================================================================
    always_comb begin
        vbl_start = 9'(`VID_VBL_START_NTSC);
        vbl_end   = 9'(`VID_VBL_END_NTSC);
        if (geo.pal) begin
            vbl_start = 9'(`VID_VBL_START_PAL);
            vbl_end   = 9'(`VID_VBL_END_PAL);
        end
        if (mono) begin
            hde_start = 7'(`VID_HDE_START_MONO);
            hde_end   = 7'(`VID_HDE_END_MONO);
            vde_start = 9'(`VID_VDE_START_MONO);
            vde_end   = 9'(`VID_VDE_END_MONO);
        end else if (geo.pal) begin
            hde_start = 7'(`VID_HDE_START_PAL);
            hde_end   = 7'(`VID_HDE_END_PAL);
            vde_start = 9'(`VID_VDE_START_PAL);
            vde_end   = 9'(`VID_VDE_END_PAL);
        end else begin
            hde_start = 7'(`VID_HDE_START_NTSC);
            hde_end   = 7'(`VID_HDE_END_NTSC);
            vde_start = 9'(`VID_VDE_START_NTSC);
            vde_end   = 9'(`VID_VDE_END_NTSC);
        end
    end

    // Vertical FSM, steps only at line starts
    always_comb begin
        state_nx = state_q;
        if (new_frame) begin
            state_nx = mono ? V_BORDER_TOP : V_TOP_BLANK;   // Mono has no top blank
        end else if (line_start) begin
            case (state_q)
                V_TOP_BLANK:  if (pos_i.vpos == vbl_start) state_nx = V_BORDER_TOP;
                V_BORDER_TOP: if (pos_i.vpos == vde_start) state_nx = V_ACTIVE;
                V_ACTIVE:     if (pos_i.vpos == vde_end) state_nx = V_BORDER_BOT;
                V_BORDER_BOT: if (!mono && pos_i.vpos == vbl_end) state_nx = V_BOT_BLANK;
                default:      state_nx = state_q;
            endcase
        end
    end

    // Horizontal set and clear at window words
    always_comb begin
        hde_nx = hde_q;
        if (pos_i.hpos == hde_start) hde_nx = 1'b1;
        if (pos_i.hpos == hde_end) hde_nx = 1'b0;
        hbl_nx = hbl_q;
        if (pos_i.hpos == 7'(`VID_HBL_START)) hbl_nx = 1'b1;
        if (pos_i.hpos == 7'(`VID_HBL_END)) hbl_nx = 1'b0;
        if (mono) hbl_nx = 1'b1;
    end

    assign vvis  = (state_nx != V_TOP_BLANK) && (state_nx != V_BOT_BLANK);
    assign de_nx = hde_nx && (state_nx == V_ACTIVE);
    assign de_o  = de_nx;                   // Valid in the word_en cycle

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            state_q        <= V_TOP_BLANK;
            geo_q          <= '0;
            hde_q          <= 1'b0;
            hbl_q          <= 1'b0;
            beam_q.hsync_n <= 1'b1;
            beam_q.vsync_n <= 1'b1;
            beam_q.de      <= 1'b0;
            beam_q.blank_n <= 1'b0;
        end else if (pos_i.word_en) begin
            state_q        <= state_nx;
            geo_q          <= geo;
            hde_q          <= hde_nx;
            hbl_q          <= hbl_nx;
            beam_q.hsync_n <= hsync_n_i;
            beam_q.vsync_n <= vsync_n_i;
            beam_q.de      <= de_nx;
            beam_q.blank_n <= hbl_nx & vvis;
        end
    end

    assign beam_o = beam_q;

endmodule

// ==== logic/vid_addr_cnt.sv ====
`timescale 1ns/1ps

module vid_addr_cnt
    import vid_pkg::*;
(
    input  logic       clk32,
    input  logic       porb,
    input  beam_pos_t  pos_i,
    input  logic       de_i,
    input  vid_addr_t  base_i,
    input  logic [7:0] hoff_i,
    output fetch_t     fetch_o,
    output vid_addr_t  cur_addr_o
);

    vid_addr_t addr_q;
    vid_addr_t fetch_addr_q;
    logic      fetch_valid_q;
    logic      de_d;                     // DE of the previous word

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            addr_q        <= '0;
            fetch_addr_q  <= '0;
            fetch_valid_q <= 1'b0;
            de_d          <= 1'b0;
        end else begin
            fetch_valid_q <= pos_i.word_en & de_i;     // One cycle strobe
            if (pos_i.word_en) begin
                de_d <= de_i;
                if (pos_i.frame_start) begin
                    addr_q <= base_i;
                end else if (de_i) begin
                    fetch_addr_q <= addr_q;
                    addr_q       <= addr_q + vid_addr_t'(1);
                end else if (de_d) begin
                    // End of the active part of a line
                    addr_q <= addr_q + vid_addr_t'(hoff_i);
                end
            end
        end
    end

    assign fetch_o.valid = fetch_valid_q;
    assign fetch_o.addr  = fetch_addr_q;
    assign cur_addr_o    = addr_q;

endmodule

// ==== logic/vid_macros.svh ====
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// ======================================================================
// Timing base
// ======================================================================
`define VID_WORD_DIV        16      // clk32 cycles per word period
`define VID_ADDR_W          21      // Word address, byte bits 21..1

// Line lengths in word periods
`define VID_LINE_PAL        128
`define VID_LINE_NTSC       127
`define VID_LINE_MONO       56

// Frame lengths in lines
`define VID_FRAME_PAL       313
`define VID_FRAME_NTSC      263
`define VID_FRAME_MONO      501

// Syncs sit at the end of the line and of the frame
`define VID_HSYNC_W         8
`define VID_HSYNC_W_MONO    4
`define VID_VSYNC_LINES     3

// ======================================================================
// Display windows, end positions exclusive
// ======================================================================
`define VID_HDE_START_PAL   12
`define VID_HDE_END_PAL     92
`define VID_HDE_START_NTSC  11
`define VID_HDE_END_NTSC    91
`define VID_HDE_START_MONO  2
`define VID_HDE_END_MONO    42

`define VID_VDE_START_PAL   62
`define VID_VDE_END_PAL     262
`define VID_VDE_START_NTSC  33
`define VID_VDE_END_NTSC    233
`define VID_VDE_START_MONO  35
`define VID_VDE_END_MONO    435

// Blanking, colour modes only
`define VID_HBL_START       9
`define VID_HBL_END         114
`define VID_VBL_START_PAL   24
`define VID_VBL_END_PAL     307
`define VID_VBL_START_NTSC  15
`define VID_VBL_END_NTSC    257

// ======================================================================
// Register byte offsets
// ======================================================================
`define VID_RA_BASE_HI      8'h01
`define VID_RA_BASE_MID     8'h03
`define VID_RA_CNT_HI       8'h05
`define VID_RA_CNT_MID      8'h07
`define VID_RA_CNT_LO       8'h09
`define VID_RA_SYNC         8'h0A
`define VID_RA_BASE_LO      8'h0D
`define VID_RA_HOFF         8'h0F
`define VID_RA_MODE         8'h60

`endif

// ==== logic/vid_pkg.sv ====
`include "vid_macros.svh"

package vid_pkg;

    // Video word address, byte address bits 21..1
    typedef logic [`VID_ADDR_W-1:0] vid_addr_t;

    // Upper bit set means mono geometry
    typedef enum logic [1:0] {
        SHIFT_LOW  = 2'b00,
        SHIFT_MID  = 2'b01,
        SHIFT_HIGH = 2'b10
    } shift_mode_e;

    typedef struct packed {
        shift_mode_e shift;
        logic        pal;         // 50 Hz colour timing when set
    } vid_cfg_t;

    // One CPU register access
    typedef struct packed {
        logic       sel;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] wdata;
    } regbus_t;

    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic de;
        logic blank_n;
    } beam_t;

    // Beam position, word_en and frame_start are one cycle pulses
    typedef struct packed {
        logic [6:0] hpos;
        logic [8:0] vpos;
        logic       word_en;
        logic       frame_start;
    } beam_pos_t;

    typedef struct packed {
        logic      valid;
        vid_addr_t addr;
    } fetch_t;

endpackage

// ==== logic/vid_regs.sv ====
`timescale 1ns/1ps
`include "vid_macros.svh"

module vid_regs
    import vid_pkg::*;
(
    input  logic       clk32,
    input  logic       porb,
    input  regbus_t    bus_i,
    input  vid_addr_t  cur_addr_i,
    output vid_cfg_t   cfg_o,
    output vid_addr_t  base_o,
    output logic [7:0] hoff_o,
    output logic [7:0] rdata_o
);

    logic      wr_en;
    logic      rd_en;
    logic      base_ld;
    logic      hoff_ld;
    logic      cfg_ld;
    vid_addr_t base_d;
    vid_cfg_t  cfg_d;

    assign wr_en = bus_i.sel & bus_i.wr;
    assign rd_en = bus_i.sel & ~bus_i.wr;

    // ==================================================================
    // Write decode and byte lane merge
    // ==================================================================
    always_comb begin
        base_d  = base_o;
        cfg_d   = cfg_o;
        base_ld = 1'b0;
        hoff_ld = 1'b0;
        cfg_ld  = 1'b0;
        if (wr_en) begin
            case (bus_i.addr)
                `VID_RA_BASE_HI: begin
                    base_d[20:15] = bus_i.wdata[5:0];
                    base_ld       = 1'b1;
                end
                `VID_RA_BASE_MID: begin
                    base_d[14:7] = bus_i.wdata;
                    base_ld      = 1'b1;
                end
                `VID_RA_BASE_LO: begin
                    base_d[6:0] = bus_i.wdata[7:1];   // Byte bit 0 has no storage
                    base_ld     = 1'b1;
                end
                `VID_RA_SYNC: begin
                    cfg_d.pal = bus_i.wdata[1];
                    cfg_ld    = 1'b1;
                end
                `VID_RA_MODE: begin
                    cfg_d.shift = shift_mode_e'(bus_i.wdata[1:0]);
                    cfg_ld      = 1'b1;
                end
                `VID_RA_HOFF: hoff_ld = 1'b1;
                default: ;                          // Counter and unmapped ignored
            endcase
        end
    end

    cpu_reg #(.payload_t(vid_addr_t)) u_base (
        .clk32  (clk32),
        .porb   (porb),
        .load_i (base_ld),
        .d_i    (base_d),
        .q_o    (base_o)
    );

    cpu_reg #(.payload_t(logic [7:0])) u_hoff (
        .clk32  (clk32),
        .porb   (porb),
        .load_i (hoff_ld),
        .d_i    (bus_i.wdata),
        .q_o    (hoff_o)
    );

    cpu_reg #(.payload_t(vid_cfg_t)) u_cfg (
        .clk32  (clk32),
        .porb   (porb),
        .load_i (cfg_ld),
        .d_i    (cfg_d),
        .q_o    (cfg_o)
    );

    // ==================================================================
    // Readback
    // ==================================================================
    always_comb begin
        rdata_o = 8'hFF;
        if (rd_en) begin
            case (bus_i.addr)
                `VID_RA_BASE_HI:  rdata_o = {2'b00, base_o[20:15]};
                `VID_RA_BASE_MID: rdata_o = base_o[14:7];
                `VID_RA_BASE_LO:  rdata_o = {base_o[6:0], 1'b0};
                `VID_RA_CNT_HI:   rdata_o = {2'b00, cur_addr_i[20:15]};
                `VID_RA_CNT_MID:  rdata_o = cur_addr_i[14:7];
                `VID_RA_CNT_LO:   rdata_o = {cur_addr_i[6:0], 1'b0};
                `VID_RA_SYNC:     rdata_o = {6'b111111, cfg_o.pal, 1'b1};
                `VID_RA_MODE:     rdata_o = {6'b000000, cfg_o.shift};
                `VID_RA_HOFF:     rdata_o = hoff_o;
                default:          rdata_o = 8'hFF;
            endcase
        end
    end

endmodule

// ==== logic/vid_top.sv ====
`timescale 1ns/1ps

module vid_top
    import vid_pkg::*;
(
    input  logic       clk32,
    input  logic       porb,
    input  regbus_t    bus_i,
    output logic [7:0] rdata_o,
    output beam_t      beam_o,
    output fetch_t     fetch_o
);

    vid_cfg_t   cfg;
    vid_addr_t  base;
    vid_addr_t  cur_addr;
    logic [7:0] hoff;
    beam_pos_t  pos;
    logic       hsync_n;
    logic       vsync_n;
    logic       de;

    // ==================================================================
    // CPU side
    // ==================================================================
    vid_regs u_regs (
        .clk32      (clk32),
        .porb       (porb),
        .bus_i      (bus_i),
        .cur_addr_i (cur_addr),
        .cfg_o      (cfg),
        .base_o     (base),
        .hoff_o     (hoff),
        .rdata_o    (rdata_o)
    );

    // ==================================================================
    // Beam side
    // ==================================================================
    beam_timer u_timer (
        .clk32     (clk32),
        .porb      (porb),
        .cfg_i     (cfg),
        .pos_o     (pos),
        .hsync_n_o (hsync_n),
        .vsync_n_o (vsync_n)
    );

    display_window_fsm u_window (
        .clk32     (clk32),
        .porb      (porb),
        .pos_i     (pos),
        .hsync_n_i (hsync_n),
        .vsync_n_i (vsync_n),
        .cfg_i     (cfg),
        .beam_o    (beam_o),
        .de_o      (de)
    );

    vid_addr_cnt u_addr (
        .clk32      (clk32),
        .porb       (porb),
        .pos_i      (pos),
        .de_i       (de),
        .base_i     (base),
        .hoff_i     (hoff),
        .fetch_o    (fetch_o),
        .cur_addr_o (cur_addr)
    );

endmodule
